// File: Bender.yml
package:
  name: video_crop

sources:
  # packages first, then the design bottom up
  - hdl/video_timing_pkg.sv
  - hdl/crop_key_pkg.sv
  - hdl/beam_counter.sv
  - hdl/blank_measure.sv
  - hdl/crop_key_fsm.sv
  - hdl/crop_window.sv
  - hdl/screen_info.sv
  - hdl/video_crop_top.sv
  - target: test
    files:
      - bench/video_source.sv
      - bench/video_crop_tb.sv

// File: bench/video_crop_tb.sv
////////////////////////////////////////
// video crop testbench
// directed tests for measurement, crop keys, window and mode flag
////////////////////////////////////////
`timescale 1ns/10ps

module video_crop_tb;

	import video_timing_pkg::*;
	import crop_key_pkg::*;

	localparam int CLK_NS      = 40;
	localparam int LINE_LEN    = 200;
	localparam int H_ACT_FIRST = 20;
	localparam int H_ACT_LAST  = 179;
	localparam int FRAME_LINES = 60;
	localparam int V_ACT_FIRST = 4;
	localparam int V_ACT_LAST  = 53;
	localparam int ACT_W       = H_ACT_LAST - H_ACT_FIRST + 1; // 160 pixels
	localparam int ACT_H       = V_ACT_LAST - V_ACT_FIRST + 1; // 50 lines
	localparam int V_KEY_STEP  = 1; // lines per crop key
	localparam int H_KEY_STEP  = 4; // pixels per crop key
	localparam logic [31:0] SEED = 32'h59b0_4a24;

	// all tests fit in about ten frames
	localparam longint WATCHDOG_NS = 64'd12 * LINE_LEN * FRAME_LINES * CLK_NS;

	logic              clk_28;
	logic              arst_n;
	logic              hsync_n, vsync_n, hblank, vblank;
	logic [RES_W-1:0]  res;
	logic              key_stb;
	logic [7:0]        key_code;
	logic              de;
	beam_cnt_t         scr_vbl_t, scr_vbl_b, scr_hbl_l, scr_hbl_r;
	beam_cnt_t         scr_hsize, scr_vsize;
	logic [RES_W-1:0]  scr_res;
	logic [FLG_W-1:0]  scr_flg;
	logic [FLG_W-1:0]  flg_ref; // steady mode count
	int                errors = 0;
	int                checks = 0;

	video_source #(
		.LINE_LEN(LINE_LEN), .H_ACT_FIRST(H_ACT_FIRST), .H_ACT_LAST(H_ACT_LAST), .HS_LEN(8),
		.FRAME_LINES(FRAME_LINES), .V_ACT_FIRST(V_ACT_FIRST), .V_ACT_LAST(V_ACT_LAST),
		.VS_LEN(2)
	) source_i (
		.clk_28, .arst_n, .hsync_n, .vsync_n, .hblank, .vblank
	);

	video_crop_top #(.CNT_W(CNT_W), .H_FORCE(H_FORCE_DEF), .V_FORCE(V_FORCE_DEF)) dut_i (
		.clk_28, .arst_n, .hsync_n, .vsync_n, .hblank, .vblank, .res, .key_stb, .key_code,
		.de, .scr_vbl_t, .scr_vbl_b, .scr_hbl_l, .scr_hbl_r,
		.scr_hsize, .scr_vsize, .scr_res, .scr_flg
	);

	initial begin
		clk_28 = 1'b0;
		forever #(CLK_NS / 2) clk_28 = ~clk_28;
	end

	initial begin
		#(WATCHDOG_NS);
		$display("timeout: the tests did not finish within 12 frames");
		$display("Testbench failed");
		$finish;
	end

	////////////////////////////////////////
	// helpers

	task automatic check_value(input string name, input logic [31:0] got,
		input logic [31:0] exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("error: %s = 0x%0h, expected 0x%0h", name, got, exp);
		end
	endtask

	// one strobe high for a cycle, then low for a cycle
	task automatic send_key(input logic [7:0] code);
		@(posedge clk_28);
		key_code <= code;
		key_stb  <= 1'b1;
		@(posedge clk_28);
		key_stb <= 1'b0;
		@(posedge clk_28);
	endtask

	task automatic press_shuffled(input logic [7:0] code_a, input int n_a,
		input logic [7:0] code_b, input int n_b);
		int left_a;
		int left_b;
		int pick;
		left_a = n_a;
		left_b = n_b;
		while (left_a + left_b > 0) begin
			pick = $urandom_range(left_a + left_b - 1);
			if (pick < left_a) begin
				send_key(code_a);
				left_a--;
			end else begin
				send_key(code_b);
				left_b--;
			end
		end
	endtask

	// snapshot lands two cycles after the DUT sees vblank fall
	task automatic wait_snapshot;
		@(negedge vblank);
		repeat (4) @(posedge clk_28);
		@(negedge clk_28);
	endtask

	task automatic check_offsets(input int t, input int b, input int l, input int r);
		check_value("scr_vbl_t", scr_vbl_t, beam_cnt_t'(t));
		check_value("scr_vbl_b", scr_vbl_b, beam_cnt_t'(b));
		check_value("scr_hbl_l", scr_hbl_l, beam_cnt_t'(l));
		check_value("scr_hbl_r", scr_hbl_r, beam_cnt_t'(r));
	endtask

	////////////////////////////////////////
	// tests

	task automatic reset_and_measure;
		wait_snapshot; // frame 0 still measuring height
		wait_snapshot;
		check_offsets(0, 0, 0, 0);
		check_value("scr_hsize", scr_hsize, ACT_W);
		check_value("scr_vsize", scr_vsize, ACT_H);
		flg_ref = scr_flg;
	endtask

	task automatic near_edge_keys;
		int n_up;
		int n_left;
		n_up   = $urandom_range(3, 1);
		n_left = $urandom_range(3, 1);
		$display("near edge keys: %0d up, %0d left", n_up, n_left);
		press_shuffled(KEY_UP, n_up, KEY_LEFT, n_left);
		wait_snapshot;
		check_offsets(n_up * V_KEY_STEP, 0, n_left * H_KEY_STEP, 0);
		press_shuffled(KEY_DOWN, n_up, KEY_RIGHT, n_left);
		wait_snapshot;
		check_offsets(0, 0, 0, 0);
	endtask

	task automatic modifier_keys;
		send_key(KEY_ALT_L);
		send_key(KEY_UP);
		send_key(KEY_LEFT);
		wait_snapshot;
		check_offsets(0, V_KEY_STEP, 0, H_KEY_STEP);
		send_key(KEY_ALT_L_UP); // back to top and left
		send_key(KEY_UP);
		send_key(KEY_LEFT);
		wait_snapshot;
		check_offsets(V_KEY_STEP, V_KEY_STEP, H_KEY_STEP, H_KEY_STEP);
	endtask

	task automatic clear_and_unlisted;
		send_key(8'h00);
		send_key(8'h42);
		send_key(8'hCC); // release code of up
		send_key(8'h66);
		wait_snapshot;
		check_offsets(V_KEY_STEP, V_KEY_STEP, H_KEY_STEP, H_KEY_STEP);
		send_key(KEY_CLEAR);
		wait_snapshot;
		check_offsets(0, 0, 0, 0);
	endtask

	task automatic window_size;
		int t_off;
		int b_off;
		int l_off;
		int r_off;
		int exp_w;
		int line_w;
		int n_lines;
		int bad_w;
		logic hs_prev;
		logic vs_prev;
		logic done;
		t_off = 3 * V_KEY_STEP;
		b_off = 2 * V_KEY_STEP;
		l_off = 2 * H_KEY_STEP;
		r_off = 1 * H_KEY_STEP;
		exp_w = ACT_W - l_off + r_off;
		press_shuffled(KEY_UP, 3, KEY_LEFT, 2);
		send_key(KEY_ALT_R);
		press_shuffled(KEY_UP, 2, KEY_LEFT, 1);
		send_key(KEY_ALT_R_UP);

		// whole frame after the keys, window settled
		@(negedge vsync_n);
		line_w  = 0;
		n_lines = 0;
		bad_w   = -1;
		hs_prev = 1'b0;
		vs_prev = 1'b0;
		done    = 1'b0;
		while (!done) begin
			@(negedge clk_28);
			if (de) line_w++;
			if (hs_prev && !hsync_n) begin // line boundary
				if (line_w != 0) begin
					n_lines++;
					if (line_w != exp_w && bad_w < 0) bad_w = line_w;
				end
				line_w = 0;
			end
			if (vs_prev && !vsync_n) done = 1'b1;
			hs_prev = hsync_n;
			vs_prev = vsync_n;
		end
		check_value("de width", (bad_w < 0) ? exp_w : bad_w, exp_w);
		check_value("de lines", n_lines, ACT_H - t_off + b_off);
	endtask

	task automatic mode_change_flag;
		logic [FLG_W-1:0] flg_next;
		flg_next = flg_ref + 1'b1;
		check_value("scr_flg", scr_flg, flg_ref); // steady since the first frames
		@(posedge clk_28);
		res <= 2'd2;
		wait_snapshot;
		check_value("scr_res", scr_res, 2'd2);
		check_value("scr_flg", scr_flg, flg_next);
		wait_snapshot;
		check_value("scr_flg", scr_flg, flg_next);
	endtask

	////////////////////////////////////////
	// main sequence

	initial begin
		void'($urandom(SEED));
		arst_n   = 1'b0;
		key_stb  = 1'b0;
		key_code = 8'h00;
		res      = '0;
		repeat (3) @(posedge clk_28);
		arst_n <= 1'b1;

		reset_and_measure();
		near_edge_keys();
		modifier_keys();
		clear_and_unlisted();
		window_size();
		mode_change_flag();

		$display("checks %0d, errors %0d", checks, errors);
		if (errors == 0) begin
			$display("Testbench passed");
		end else begin
			$display("Testbench failed");
		end
		$finish;
	end

endmodule

// File: bench/video_source.sv
////////////////////////////////////////
// video source model
// counter based sync and blank pattern for the crop unit
////////////////////////////////////////
`timescale 1ns/10ps

module video_source #(
	parameter int LINE_LEN    = 200,
	parameter int H_ACT_FIRST = 20,
	parameter int H_ACT_LAST  = 179,
	parameter int HS_LEN      = 8,
	parameter int FRAME_LINES = 60,
	parameter int V_ACT_FIRST = 4,
	parameter int V_ACT_LAST  = 53,
	parameter int VS_LEN      = 2
) (
	input  logic clk_28,
	input  logic arst_n,
	output logic hsync_n,
	output logic vsync_n,
	output logic hblank,
	output logic vblank
);

	int x; // pixel within the line
	int y; // line within the frame
	int x_nxt;
	int y_nxt;

	assign x_nxt = (x == LINE_LEN - 1) ? 0 : x + 1;
	assign y_nxt = (x != LINE_LEN - 1) ? y : (y == FRAME_LINES - 1) ? 0 : y + 1;

	// outputs always match the registered position
	always_ff @(posedge clk_28 or negedge arst_n) begin
		if (!arst_n) begin
			x       <= 0;
			y       <= 0;
			hsync_n <= 1'b0;
			vsync_n <= 1'b0;
			hblank  <= 1'b1;
			vblank  <= 1'b1;
		end else begin
			x       <= x_nxt;
			y       <= y_nxt;
			hsync_n <= (x_nxt >= HS_LEN); // sync at the start of each line
			hblank  <= (x_nxt < H_ACT_FIRST) || (x_nxt > H_ACT_LAST);
			vsync_n <= (y_nxt >= VS_LEN);
			vblank  <= (y_nxt < V_ACT_FIRST) || (y_nxt > V_ACT_LAST);
		end
	end

endmodule

// File: hdl/beam_counter.sv
////////////////////////////////////////
// beam counter
// pixel and line position plus sync and blank edge pulses
////////////////////////////////////////
`timescale 1ns/10ps

module beam_counter #(
	parameter int CNT_W = video_timing_pkg::CNT_W
) (
	input  logic             clk_28,
	input  logic             arst_n,
	input  logic             hsync_n,
	input  logic             vsync_n,
	input  logic             hblank,
	input  logic             vblank,
	output logic [CNT_W-1:0] hcnt,
	output logic [CNT_W-1:0] vcnt,
	output logic             hs_fall,
	output logic             hbl_rise,
	output logic             hbl_fall,
	output logic             vbl_rise,
	output logic             vbl_fall
);

	logic hs_q;  // registered input levels
	logic vs_q;
	logic hbl_q;
	logic vbl_q;

	////////////////////////////////////////
	// edge detection

	always_ff @(posedge clk_28 or negedge arst_n) begin
		if (!arst_n) begin
			hs_q     <= 1'b1;
			vs_q     <= 1'b1;
			hbl_q    <= 1'b0;
			vbl_q    <= 1'b0;
			hs_fall  <= 1'b0;
			hbl_rise <= 1'b0;
			hbl_fall <= 1'b0;
			vbl_rise <= 1'b0;
			vbl_fall <= 1'b0;
		end else begin
			hs_q     <= hsync_n;
			vs_q     <= vsync_n;
			hbl_q    <= hblank;
			vbl_q    <= vblank;
			hs_fall  <= hs_q & ~hsync_n;
			hbl_rise <= ~hbl_q & hblank;
			hbl_fall <= hbl_q & ~hblank;
			vbl_rise <= ~vbl_q & vblank;
			vbl_fall <= vbl_q & ~vblank;
		end
	end

	////////////////////////////////////////
	// beam position

	// hcnt still holds the full line count during the hs_fall pulse
	always_ff @(posedge clk_28 or negedge arst_n) begin
		if (!arst_n) begin
			hcnt <= '0;
			vcnt <= '0;
		end else begin
			if (!hs_q) hcnt <= '0;
			else       hcnt <= hcnt + 1'b1;

			if (!vs_q)        vcnt <= '0;
			else if (hs_fall) vcnt <= vcnt + 1'b1; // one line per hsync
		end
	end

endmodule

// File: hdl/blank_measure.sv
////////////////////////////////////////
// blank measure
// latches source blank positions, line and frame length, picture size
////////////////////////////////////////
`timescale 1ns/10ps

module blank_measure #(
	parameter int CNT_W = video_timing_pkg::CNT_W
) (
	input  logic             clk_28,
	input  logic             arst_n,
	input  logic [CNT_W-1:0] hcnt,
	input  logic [CNT_W-1:0] vcnt,
	input  logic             hs_fall,
	input  logic             hbl_rise,
	input  logic             hbl_fall,
	input  logic             vbl_rise,
	input  logic             vbl_fall,
	output logic [CNT_W-1:0] h_start,
	output logic [CNT_W-1:0] h_end,
	output logic [CNT_W-1:0] h_max,
	output logic [CNT_W-1:0] v_start,
	output logic [CNT_W-1:0] v_end,
	output logic [CNT_W-1:0] v_max,
	output logic [CNT_W-1:0] hsize,
	output logic [CNT_W-1:0] vsize
);

	logic [CNT_W-1:0] vcnt_q; // previous line count

	always_ff @(posedge clk_28 or negedge arst_n) begin
		if (!arst_n) begin
			h_start <= '0;
			h_end   <= '0;
			h_max   <= '0;
			v_start <= '0;
			v_end   <= '0;
			v_max   <= '0;
			hsize   <= '0;
			vsize   <= '0;
			vcnt_q  <= '0;
		end else begin
			vcnt_q <= vcnt;

			////////////////////////////////////////
			// horizontal

			if (hbl_fall) h_start <= hcnt; // first active pixel
			if (hbl_rise) begin
				h_end <= hcnt;
				hsize <= hcnt - h_start;
			end
			if (hs_fall) h_max <= hcnt;

			////////////////////////////////////////
			// vertical

			if (vbl_fall) v_start <= vcnt;
			if (vbl_rise) begin
				v_end <= vcnt;
				vsize <= vcnt - v_start;
			end

			// vsync falling clears vcnt, so the last value is the frame length
			if (vcnt == '0 && vcnt_q != '0) v_max <= vcnt_q;
		end
	end

endmodule

// File: hdl/crop_key_fsm.sv
////////////////////////////////////////
// crop key FSM
// turns key strobes into crop offset steps
////////////////////////////////////////
`timescale 1ns/10ps

module crop_key_fsm #(
	parameter int CNT_W = video_timing_pkg::CNT_W
) (
	input  logic             clk_28,
	input  logic             arst_n,
	input  logic             key_stb,
	input  logic [7:0]       key_code,
	output logic [CNT_W-1:0] vbl_t,
	output logic [CNT_W-1:0] vbl_b,
	output logic [CNT_W-1:0] hbl_l,
	output logic [CNT_W-1:0] hbl_r
);

	import crop_key_pkg::*;

	localparam logic [CNT_W-1:0] V_INC = CNT_W'(V_STEP);
	localparam logic [CNT_W-1:0] H_INC = CNT_W'(H_STEP);

	logic       stb_q;
	logic       take; // rising edge of the strobe
	key_code_e  code;
	mod_state_e mod_q;

	assign take = key_stb & ~stb_q;
	assign code = key_code_e'(key_code);

	always_ff @(posedge clk_28 or negedge arst_n) begin
		if (!arst_n) begin
			stb_q <= 1'b0;
			mod_q <= MOD_NEAR;
			vbl_t <= '0;
			vbl_b <= '0;
			hbl_l <= '0;
			hbl_r <= '0;
		end else begin
			stb_q <= key_stb;
			if (take) begin
				case (code)
					KEY_CLEAR: begin
						vbl_t <= '0;
						vbl_b <= '0;
						hbl_l <= '0;
						hbl_r <= '0;
					end
					KEY_UP: begin
						if (mod_q == MOD_FAR) vbl_b <= vbl_b + V_INC;
						else                  vbl_t <= vbl_t + V_INC;
					end
					KEY_DOWN: begin
						if (mod_q == MOD_FAR) vbl_b <= vbl_b - V_INC;
						else                  vbl_t <= vbl_t - V_INC;
					end
					KEY_LEFT: begin
						if (mod_q == MOD_FAR) hbl_r <= hbl_r + H_INC;
						else                  hbl_l <= hbl_l + H_INC;
					end
					KEY_RIGHT: begin
						if (mod_q == MOD_FAR) hbl_r <= hbl_r - H_INC;
						else                  hbl_l <= hbl_l - H_INC;
					end
					KEY_ALT_L, KEY_ALT_R:       mod_q <= MOD_FAR;  // alt held
					KEY_ALT_L_UP, KEY_ALT_R_UP: mod_q <= MOD_NEAR; // alt released
					default: ; // other keys belong to someone else
				endcase
			end
		end
	end

endmodule

// File: hdl/crop_key_pkg.sv
////////////////////////////////////////
// crop key definitions
// scan codes, modifier state and step sizes
////////////////////////////////////////

package crop_key_pkg;

	// scan codes taken by the crop adjust logic
	typedef enum logic [7:0] {
		KEY_CLEAR    = 8'h41, // backspace
		KEY_UP       = 8'h4C,
		KEY_DOWN     = 8'h4D,
		KEY_RIGHT    = 8'h4E,
		KEY_LEFT     = 8'h4F,
		KEY_ALT_L    = 8'h64,
		KEY_ALT_R    = 8'h65,
		KEY_ALT_L_UP = 8'hE4, // release codes carry bit 7
		KEY_ALT_R_UP = 8'hE5
	} key_code_e;

	// near edge is top/left, far edge is bottom/right
	typedef enum logic {MOD_NEAR = 1'b0, MOD_FAR = 1'b1} mod_state_e;

	localparam int V_STEP = 1; // lines per key
	localparam int H_STEP = 4; // pixels per key

endpackage

// File: hdl/crop_window.sv
////////////////////////////////////////
// crop window
// shifted and forced blank flags, registered data enable
////////////////////////////////////////
`timescale 1ns/10ps

module crop_window #(
	parameter int CNT_W   = video_timing_pkg::CNT_W,
	parameter int H_FORCE = video_timing_pkg::H_FORCE_DEF,
	parameter int V_FORCE = video_timing_pkg::V_FORCE_DEF
) (
	input  logic             clk_28,
	input  logic             arst_n,
	input  logic             hsync_n,
	input  logic             vsync_n,
	input  logic [CNT_W-1:0] hcnt,
	input  logic [CNT_W-1:0] vcnt,
	input  logic [CNT_W-1:0] h_start,
	input  logic [CNT_W-1:0] h_end,
	input  logic [CNT_W-1:0] h_max,
	input  logic [CNT_W-1:0] v_start,
	input  logic [CNT_W-1:0] v_end,
	input  logic [CNT_W-1:0] v_max,
	input  logic [CNT_W-1:0] vbl_t,
	input  logic [CNT_W-1:0] vbl_b,
	input  logic [CNT_W-1:0] hbl_l,
	input  logic [CNT_W-1:0] hbl_r,
	output logic             de
);

	localparam logic [CNT_W-1:0] H_MARGIN = CNT_W'(H_FORCE);
	localparam logic [CNT_W-1:0] V_MARGIN = CNT_W'(V_FORCE);

	logic [CNT_W-1:0] h_open, h_close, h_fclose; // compare points, wrap at CNT_W
	logic [CNT_W-1:0] v_open, v_close, v_fclose;
	logic             shbl, fhbl, svbl, fvbl;    // shifted and forced blank
	logic             line_blank, frame_blank;
	logic             lbl_q;

	assign h_open   = h_start + hbl_l - CNT_W'(2);
	assign h_close  = h_end + hbl_r - CNT_W'(2);
	assign h_fclose = h_max - H_MARGIN;
	assign v_open   = v_start + vbl_t - CNT_W'(1);
	assign v_close  = v_end + vbl_b - CNT_W'(1);
	assign v_fclose = v_max - V_MARGIN;

	assign line_blank  = fhbl | shbl | ~hsync_n;
	assign frame_blank = fvbl | svbl | ~vsync_n;

	always_ff @(posedge clk_28 or negedge arst_n) begin
		if (!arst_n) begin
			shbl  <= 1'b1;
			fhbl  <= 1'b1;
			svbl  <= 1'b1;
			fvbl  <= 1'b1;
			lbl_q <= 1'b1;
			de    <= 1'b0;
		end else begin
			if (hcnt == h_open)   shbl <= 1'b0;
			if (hcnt == h_close)  shbl <= 1'b1;
			if (hcnt == H_MARGIN) fhbl <= 1'b0; // keep off the hsync edges
			if (hcnt == h_fclose) fhbl <= 1'b1;

			lbl_q <= line_blank;

			// vertical flags move only when the line window opens
			if (lbl_q & ~line_blank) begin
				if (vcnt == v_open)   svbl <= 1'b0;
				if (vcnt == v_close)  svbl <= 1'b1;
				if (vcnt == V_MARGIN) fvbl <= 1'b0;
				if (vcnt == v_fclose) fvbl <= 1'b1;
			end

			// delayed line blank so a line sees one frame blank value
			de <= ~(lbl_q | frame_blank);
		end
	end

endmodule

// File: hdl/screen_info.sv
////////////////////////////////////////
// screen info
// per-frame snapshot for the host plus mode change counter
////////////////////////////////////////
`timescale 1ns/10ps

module screen_info #(
	parameter int CNT_W = video_timing_pkg::CNT_W
) (
	input  logic                                clk_28,
	input  logic                                arst_n,
	input  logic                                vbl_fall,
	input  logic [CNT_W-1:0]                    vbl_t,
	input  logic [CNT_W-1:0]                    vbl_b,
	input  logic [CNT_W-1:0]                    hbl_l,
	input  logic [CNT_W-1:0]                    hbl_r,
	input  logic [CNT_W-1:0]                    hsize,
	input  logic [CNT_W-1:0]                    vsize,
	input  logic [video_timing_pkg::RES_W-1:0] res,
	output logic [CNT_W-1:0]                    scr_vbl_t,
	output logic [CNT_W-1:0]                    scr_vbl_b,
	output logic [CNT_W-1:0]                    scr_hbl_l,
	output logic [CNT_W-1:0]                    scr_hbl_r,
	output logic [CNT_W-1:0]                    scr_hsize,
	output logic [CNT_W-1:0]                    scr_vsize,
	output logic [video_timing_pkg::RES_W-1:0] scr_res,
	output logic [video_timing_pkg::FLG_W-1:0] scr_flg
);

	logic mode_chg; // new mode against the last snapshot

	assign mode_chg = (res != scr_res) || (hsize != scr_hsize) || (vsize != scr_vsize);

	always_ff @(posedge clk_28 or negedge arst_n) begin
		if (!arst_n) begin
			scr_vbl_t <= '0;
			scr_vbl_b <= '0;
			scr_hbl_l <= '0;
			scr_hbl_r <= '0;
			scr_hsize <= '0;
			scr_vsize <= '0;
			scr_res   <= '0;
			scr_flg   <= '0;
		end else if (vbl_fall) begin // once per frame
			scr_vbl_t <= vbl_t;
			scr_vbl_b <= vbl_b;
			scr_hbl_l <= hbl_l;
			scr_hbl_r <= hbl_r;
			scr_hsize <= hsize;
			scr_vsize <= vsize;
			scr_res   <= res;
			if (mode_chg) scr_flg <= scr_flg + 1'b1;
		end
	end

endmodule

// File: hdl/video_crop_top.sv
////////////////////////////////////////
// video crop top
// beam counting, blank measurement, key crop and host snapshot
////////////////////////////////////////
`timescale 1ns/10ps

module video_crop_top #(
	parameter int CNT_W   = video_timing_pkg::CNT_W,
	parameter int H_FORCE = video_timing_pkg::H_FORCE_DEF,
	parameter int V_FORCE = video_timing_pkg::V_FORCE_DEF
) (
	input  logic                                clk_28,
	input  logic                                arst_n,
	input  logic                                hsync_n,
	input  logic                                vsync_n,
	input  logic                                hblank,
	input  logic                                vblank,
	input  logic [video_timing_pkg::RES_W-1:0] res,
	input  logic                                key_stb,
	input  logic [7:0]                          key_code,
	output logic                                de,
	output video_timing_pkg::beam_cnt_t         scr_vbl_t,
	output video_timing_pkg::beam_cnt_t         scr_vbl_b,
	output video_timing_pkg::beam_cnt_t         scr_hbl_l,
	output video_timing_pkg::beam_cnt_t         scr_hbl_r,
	output video_timing_pkg::beam_cnt_t         scr_hsize,
	output video_timing_pkg::beam_cnt_t         scr_vsize,
	output logic [video_timing_pkg::RES_W-1:0] scr_res,
	output logic [video_timing_pkg::FLG_W-1:0] scr_flg
);

	logic [CNT_W-1:0] hcnt, vcnt;
	logic             hs_fall, hbl_rise, hbl_fall, vbl_rise, vbl_fall;
	logic [CNT_W-1:0] h_start, h_end, h_max, v_start, v_end, v_max;
	logic [CNT_W-1:0] hsize, vsize;
	logic [CNT_W-1:0] vbl_t, vbl_b, hbl_l, hbl_r; // live crop offsets

	beam_counter #(.CNT_W(CNT_W)) beam_i (
		.clk_28, .arst_n, .hsync_n, .vsync_n, .hblank, .vblank,
		.hcnt, .vcnt, .hs_fall, .hbl_rise, .hbl_fall, .vbl_rise, .vbl_fall
	);

	blank_measure #(.CNT_W(CNT_W)) measure_i (
		.clk_28, .arst_n, .hcnt, .vcnt,
		.hs_fall, .hbl_rise, .hbl_fall, .vbl_rise, .vbl_fall,
		.h_start, .h_end, .h_max, .v_start, .v_end, .v_max, .hsize, .vsize
	);

	crop_key_fsm #(.CNT_W(CNT_W)) key_i (
		.clk_28, .arst_n, .key_stb, .key_code, .vbl_t, .vbl_b, .hbl_l, .hbl_r
	);

	crop_window #(.CNT_W(CNT_W), .H_FORCE(H_FORCE), .V_FORCE(V_FORCE)) window_i (
		.clk_28, .arst_n, .hsync_n, .vsync_n, .hcnt, .vcnt,
		.h_start, .h_end, .h_max, .v_start, .v_end, .v_max,
		.vbl_t, .vbl_b, .hbl_l, .hbl_r, .de
	);

	screen_info #(.CNT_W(CNT_W)) info_i (
		.clk_28, .arst_n, .vbl_fall, .vbl_t, .vbl_b, .hbl_l, .hbl_r,
		.hsize, .vsize, .res,
		.scr_vbl_t, .scr_vbl_b, .scr_hbl_l, .scr_hbl_r,
		.scr_hsize, .scr_vsize, .scr_res, .scr_flg
	);

endmodule

// File: hdl/video_timing_pkg.sv
////////////////////////////////////////
// video timing definitions
// beam counter width, blank margins and snapshot field widths
////////////////////////////////////////

package video_timing_pkg;

	////////////////////////////////////////
	// beam position

	// enough for 4095 pixels per line or lines per frame
	localparam int CNT_W = 12;

	// positions, measured sizes and crop offsets
	typedef logic [CNT_W-1:0] beam_cnt_t;

	////////////////////////////////////////
	// forced blank margins

	localparam int H_FORCE_DEF = 8; // pixels at each end of a line
	localparam int V_FORCE_DEF = 3; // lines at each end of a frame

	////////////////////////////////////////
	// host snapshot fields

	localparam int RES_W = 2; // resolution code from the video source
	localparam int FLG_W = 7; // mode change counter, wraps

endpackage

// File: video_crop.f
hdl/video_timing_pkg.sv
hdl/crop_key_pkg.sv
hdl/beam_counter.sv
hdl/blank_measure.sv
hdl/crop_key_fsm.sv
hdl/crop_window.sv
hdl/screen_info.sv
hdl/video_crop_top.sv
bench/video_source.sv
bench/video_crop_tb.sv
